// ==== all.f ====
hdl/uart_frame_pkg.sv
hdl/uart_ctrl_pkg.sv
hdl/uart_cmd_tx.sv
hdl/uart_rx.sv
hdl/uart.sv
dv/uart_tb.sv

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ns

module uart_tb;

  import uart_frame_pkg::*;

  localparam int CLK_FREQ     = 10_000_000;
  localparam int BAUD         = 115_200;
  localparam bit CHECK        = 1'b1;
  localparam int CMD_WIDTH    = 16;
  localparam int BIT_CYCLES   = CLK_FREQ / BAUD;
  localparam int FRAME_BITS   = frame_bits(CHECK);
  localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;
  localparam int CMD_FRAMES   = CMD_WIDTH / DATA_BITS;
  localparam int N_CLEAN      = 4;
  localparam int N_LOOP       = 3;
  // frames on the line over all tests with idle gaps counted as frames
  localparam int TOTAL_FRAMES = CMD_FRAMES + (CMD_FRAMES + 1) + 2 * N_CLEAN + 4
                                + N_LOOP * CMD_FRAMES;
  localparam longint WATCHDOG_NS = 2 * TOTAL_FRAMES * FRAME_CYCLES * 100;

  logic                 clk;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 tx;
  logic                 rx;
  logic                 read_rdy;
  rx_result_t           read_data;
  logic                 loopback;
  logic                 line_drv;

  // rx from the dut's own tx or from the tb line driver
  assign rx = loopback ? tx : line_drv;

  uart #(
    .CLK_FREQ  (CLK_FREQ),
    .BAUD      (BAUD),
    .CHECK     (CHECK),
    .CMD_WIDTH (CMD_WIDTH)
  ) uart_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: got %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_error($sformatf("%s: got %0d cycles, expected %0d", what, got, exp));
    end
  endtask

  // expected parity counted from the byte one bit at a time
  function automatic logic parity_for_odd(input data_t data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < DATA_BITS; i++) begin
      ones = ones + int'(data[i]);
    end
    return (ones % 2) == 0;
  endfunction

  task automatic check_byte(input data_t got, input logic got_par, input data_t exp,
                            input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: data %h, expected %h", what, got, exp));
    end
    check_level(got_par, parity_for_odd(exp), {what, " parity"});
  endtask

  function automatic rx_result_t expect_result(input logic err, input data_t data);
    rx_result_t res;
    res.err  = err;
    res.data = data;
    return res;
  endfunction

  task automatic check_result(input rx_result_t got, input rx_result_t exp,
                              input string what);
    if (got !== exp) begin
      report_error($sformatf("%s: err %b data %h, expected err %b data %h",
                             what, got.err, got.data, exp.err, exp.data));
    end
  endtask

  // the second edge accepts when cmd_rdy is high
  task automatic issue_cmd(input logic [CMD_WIDTH-1:0] word);
    @(posedge clk);
    cmd_in  <= word;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
  endtask

  task automatic wait_result(output rx_result_t res);
    @(negedge clk);
    while (!read_rdy) @(negedge clk);
    res = read_data;
  endtask

  task automatic send_line(input data_t data, input logic bad_par, input logic stop);
    logic [FRAME_BITS-1:0] bits;
    int i;
    bits = {stop, parity_for_odd(data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    for (i = 0; i < FRAME_BITS; i++) begin
      line_drv <= bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
    end
    line_drv <= 1'b1;
  endtask

  task automatic capture_frame(output data_t data, output logic par);
    logic [FRAME_BITS-1:0] bits;
    int i;
    @(negedge tx);
    repeat (BIT_CYCLES / 2) @(negedge clk);
    for (i = 0; i < FRAME_BITS; i++) begin
      if (i > 0) repeat (BIT_CYCLES) @(negedge clk);
      bits[i] = tx;
    end
    check_level(bits[0], 1'b0, "start bit");
    check_level(bits[FRAME_BITS-1], 1'b1, "stop bit");
    data = bits[DATA_BITS:1];
    par  = bits[DATA_BITS+1];
  endtask

  // both lines idle and no result strobes
  task automatic hold_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_level(tx, 1'b1, "tx idle");
      check_level(read_rdy, 1'b0, "no read_rdy while idle");
    end
  endtask

  task automatic reset_state();
    check_level(tx, 1'b1, "tx after reset");
    check_level(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_level(read_rdy, 1'b0, "read_rdy after reset");
  endtask

  task automatic cmd_transmit();
    logic [CMD_WIDTH-1:0] word;
    data_t hi;
    data_t lo;
    logic par_hi;
    logic par_lo;
    int busy;
    word = 16'($urandom);
    check_level(cmd_rdy, 1'b1, "cmd_rdy before command");
    fork
      begin
        issue_cmd(word);
        busy = 0;
        @(negedge clk);
        while (!cmd_rdy) begin
          busy++;
          @(negedge clk);
        end
      end
      begin
        capture_frame(hi, par_hi);
        capture_frame(lo, par_lo);
      end
    join
    check_byte(hi, par_hi, word[15:8], "high byte");
    check_byte(lo, par_lo, word[7:0], "low byte");
    check_count(busy, CMD_FRAMES * FRAME_CYCLES, "cmd_rdy low time");
  endtask

  task automatic busy_rejection();
    logic [CMD_WIDTH-1:0] word;
    data_t hi;
    data_t lo;
    logic par_hi;
    logic par_lo;
    word = 16'($urandom);
    fork
      begin
        issue_cmd(word);
        repeat (100) @(posedge clk);
        cmd_in  <= ~word;
        cmd_vld <= 1'b1;
        repeat (5) @(posedge clk);
        cmd_vld <= 1'b0;
        wait_ready();
      end
      begin
        capture_frame(hi, par_hi);
        capture_frame(lo, par_lo);
      end
    join
    check_byte(hi, par_hi, word[15:8], "high byte while busy");
    check_byte(lo, par_lo, word[7:0], "low byte while busy");
    // a taken second command would start a third frame here
    hold_quiet(FRAME_CYCLES);
  endtask

  task automatic clean_receive();
    data_t b;
    rx_result_t got;
    int n;
    for (n = 0; n < N_CLEAN; n++) begin
      b = 8'($urandom);
      fork
        send_line(b, 1'b0, 1'b1);
        wait_result(got);
      join
      check_result(got, expect_result(1'b0, b), "clean receive");
      hold_quiet(FRAME_CYCLES);
    end
  endtask

  task automatic receive_errors();
    data_t b;
    rx_result_t got;
    b = 8'($urandom);
    fork
      send_line(b, 1'b1, 1'b1);
      wait_result(got);
    join
    check_result(got, expect_result(1'b1, b), "inverted parity");
    hold_quiet(FRAME_CYCLES);
    b = 8'($urandom);
    fork
      send_line(b, 1'b0, 1'b0);
      wait_result(got);
    join
    check_result(got, expect_result(1'b1, b), "low stop bit");
    hold_quiet(FRAME_CYCLES);
  endtask

  task automatic loopback_traffic();
    logic [CMD_WIDTH-1:0] word;
    rx_result_t r_hi;
    rx_result_t r_lo;
    int n;
    @(posedge clk);
    loopback <= 1'b1;
    for (n = 0; n < N_LOOP; n++) begin
      word = 16'($urandom);
      fork
        issue_cmd(word);
        begin
          wait_result(r_hi);
          wait_result(r_lo);
        end
      join
      check_result(r_hi, expect_result(1'b0, word[15:8]), "loopback high byte");
      check_result(r_lo, expect_result(1'b0, word[7:0]), "loopback low byte");
      wait_ready();
    end
  endtask

  initial begin
    void'($urandom(32'hc169));
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    line_drv = 1'b1;
    loopback = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_state();
    cmd_transmit();
    busy_rejection();
    clean_receive();
    receive_errors();
    loopback_traffic();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== hdl/uart.sv ====
`timescale 1ns/1ns

module uart #(
  parameter int CLK_FREQ  = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter bit CHECK     = 1'b1,
  parameter int CMD_WIDTH = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [CMD_WIDTH-1:0]       cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output logic                       read_rdy,
  output uart_frame_pkg::rx_result_t read_data
);

  // command words out, msb byte first
  uart_cmd_tx #(
    .CLK_FREQ  (CLK_FREQ),
    .BAUD      (BAUD),
    .CHECK     (CHECK),
    .CMD_WIDTH (CMD_WIDTH)
  ) cmd_tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .tx      (tx)
  );

  // independent receive path
  uart_rx #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD     (BAUD),
    .CHECK    (CHECK)
  ) rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// ==== hdl/uart_cmd_tx.sv ====
`timescale 1ns/1ns

module uart_cmd_tx #(
  parameter int CLK_FREQ  = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter bit CHECK     = 1'b1,
  parameter int CMD_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx
);

  import uart_frame_pkg::*;
  import uart_ctrl_pkg::*;

  localparam int BIT_CYCLES = CLK_FREQ / BAUD;
  localparam int CNT_W      = $clog2(BIT_CYCLES);
  localparam int NUM_BYTES  = CMD_WIDTH / DATA_BITS;
  localparam int BYTE_W     = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;
  // position of the stop bit within a frame
  localparam int LAST_POS   = frame_bits(CHECK) - 1;

  tx_state_e            state;
  logic [CMD_WIDTH-1:0] cmd_hold;
  logic [CNT_W-1:0]     baud_cnt;
  logic [3:0]           bit_pos;
  logic [BYTE_W-1:0]    byte_idx;
  data_t                cur_byte;
  logic                 accept;
  logic                 bit_end;

  if (CMD_WIDTH % DATA_BITS != 0) begin : g_width_check
    $error("CMD_WIDTH must be a multiple of 8");
  end

  assign accept   = cmd_vld && cmd_rdy;
  assign bit_end  = (baud_cnt == CNT_W'(BIT_CYCLES - 1));
  assign cur_byte = cmd_hold[byte_idx*DATA_BITS +: DATA_BITS];

  // command holding register
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_hold <= cmd_in;
    end
  end

  // restarts at every bit boundary
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (state == TX_IDLE || bit_end) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= TX_IDLE;
      bit_pos  <= '0;
      byte_idx <= '0;
      tx       <= 1'b1;
      cmd_rdy  <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (accept) begin
            state    <= TX_START;
            bit_pos  <= '0;
            byte_idx <= BYTE_W'(NUM_BYTES - 1);
            tx       <= 1'b0;
            cmd_rdy  <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_pos <= bit_pos + 1'b1;
            tx      <= cur_byte[bit_pos[2:0]];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_pos <= bit_pos + 1'b1;
            if (bit_pos == 4'(DATA_BITS)) begin
              // no parity slot means the stop bit comes next
              if (bit_pos + 1'b1 == 4'(LAST_POS)) begin
                state <= TX_STOP;
                tx    <= 1'b1;
              end else begin
                state <= TX_PARITY;
                tx    <= odd_parity(cur_byte);
              end
            end else begin
              tx <= cur_byte[bit_pos[2:0]];
            end
          end
        end
        TX_PARITY: begin
          if (bit_end) begin
            state   <= TX_STOP;
            bit_pos <= bit_pos + 1'b1;
            tx      <= 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            if (byte_idx == '0) begin
              state   <= TX_IDLE;
              cmd_rdy <= 1'b1;
            end else begin
              // next lower byte, no idle gap
              state    <= TX_START;
              bit_pos  <= '0;
              byte_idx <= byte_idx - 1'b1;
              tx       <= 1'b0;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    state == TX_IDLE |-> tx);

  a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    state != TX_IDLE |-> !cmd_rdy);

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    state != TX_IDLE |=> $stable(cmd_hold));

endmodule

// ==== hdl/uart_ctrl_pkg.sv ====
package uart_ctrl_pkg;

  // transmit controller, one state per field of the frame
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  // receive controller
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

// ==== hdl/uart_frame_pkg.sv ====
package uart_frame_pkg;

  // payload bits carried by one frame
  localparam int DATA_BITS = 8;

  typedef logic [DATA_BITS-1:0] data_t;

  // received byte with its error flag on top
  typedef struct packed {
    logic  err;
    data_t data;
  } rx_result_t;

  // start, data, optional parity, stop
  function automatic int frame_bits(input bit check);
    if (check) begin
      return DATA_BITS + 3;
    end
    return DATA_BITS + 2;
  endfunction

  // odd parity, total count of ones including this bit is odd
  function automatic logic odd_parity(input data_t data);
    return ~^data;
  endfunction

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLK_FREQ = 50_000_000,
  parameter int BAUD     = 115_200,
  parameter bit CHECK    = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx,
  output logic                       read_rdy,
  output uart_frame_pkg::rx_result_t read_data
);

  import uart_frame_pkg::*;
  import uart_ctrl_pkg::*;

  localparam int BIT_CYCLES  = CLK_FREQ / BAUD;
  localparam int HALF_CYCLES = BIT_CYCLES / 2;
  localparam int CNT_W       = $clog2(BIT_CYCLES);
  localparam int LAST_POS    = frame_bits(CHECK) - 1;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] sample_cnt;
  logic [3:0]       bit_pos;
  data_t            shift;
  logic             par_bit;
  logic             sample;
  logic             err;

  // two-flop synchronizer for a line that idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // half a bit to the start midpoint and whole bits after that
  assign sample = (state == RX_START) ? (sample_cnt == CNT_W'(HALF_CYCLES - 1))
                                      : (sample_cnt == CNT_W'(BIT_CYCLES - 1));

  // parity mismatch or framing error
  assign err = (CHECK && (par_bit != odd_parity(shift))) || !rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_cnt <= '0;
    end else if (state == RX_IDLE || sample) begin
      sample_cnt <= '0;
    end else begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      bit_pos <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (!rx_sync) begin
            state   <= RX_START;
            bit_pos <= '0;
          end
        end
        RX_START: begin
          if (sample) begin
            // high at midpoint means a glitch
            if (rx_sync) begin
              state <= RX_IDLE;
            end else begin
              state   <= RX_DATA;
              bit_pos <= bit_pos + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (sample) begin
            bit_pos <= bit_pos + 1'b1;
            if (bit_pos == 4'(DATA_BITS)) begin
              state <= (bit_pos + 1'b1 == 4'(LAST_POS)) ? RX_STOP : RX_PARITY;
            end
          end
        end
        RX_PARITY: begin
          if (sample) begin
            state   <= RX_STOP;
            bit_pos <= bit_pos + 1'b1;
          end
        end
        RX_STOP: begin
          if (sample) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data shifts in lsb first
  always_ff @(posedge clk) begin
    if (sample) begin
      case (state)
        RX_DATA:   shift     <= {rx_sync, shift[DATA_BITS-1:1]};
        RX_PARITY: par_bit   <= rx_sync;
        RX_STOP:   read_data <= '{err: err, data: shift};
        default:   ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= (state == RX_STOP) && sample;
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy);

  a_pulse_from_stop: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read_rdy) |-> $past(state) == RX_STOP && $past(bit_pos) == 4'(LAST_POS));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
# Exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ns \
  -f all.f \
  --top-module uart_tb \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vuart_tb 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
